// ==== design/bus_responder.sv ====
`default_nettype none

`include "flow_ctl_consts.svh"

module bus_responder
   import flow_ctl_pkg::*;
#(
   parameter logic [15:0] BASE_OFFSET = 16'h0000
) (
   input  logic       Bus2IP_Clk,
   input  logic       reset,
   input  logic       bus_cs,
   input  logic       bus_rnw,
   input  bus_addr_t  bus_addr,
   input  tbl_field_t flow_table_status,
   input  tbl_field_t flow_table_sel,
   input  tbl_field_t flow_table_config,
   input  tbl_index_t mac_tcam_addr,
   input  mac_addr_t  mac_tcam_din,
   input  mac_addr_t  mac_tcam_din_mask,
   input  tbl_index_t ip_tcam_addr,
   input  ip_addr_t   ip_tcam_din,
   input  ip_addr_t   ip_tcam_din_mask,
   input  timestamp_t ts_tap0,
   input  timestamp_t ts_tap1,
   input  timestamp_t ts_trig,
   input  timestamp_t ts_mac_first,
   input  timestamp_t ts_mac_last,
   input  timestamp_t ts_ip_first,
   input  timestamp_t ts_ip_last,
   output bus_word_t  bus_rdata,
   output logic       bus_rd_ack,
   output logic       bus_wr_ack
);

   localparam int CNT_W = $clog2(`FC_RD_WAIT + 1);

   rd_state_e        rd_state;
   logic [CNT_W-1:0] rd_cnt;
   logic             rd_done;
   logic [15:0]      rel_addr;
   bus_word_t        rd_word;

   assign rel_addr = bus_addr[15:0] - BASE_OFFSET;

   always_comb begin
      case (rel_addr)
         `FC_FLOW_TBL_SEL:       rd_word = bus_word_t'(flow_table_sel);
         `FC_FLOW_TBL_CONF:      rd_word = bus_word_t'(flow_table_config);
         `FC_FLOW_TBL_STATUS:    rd_word = bus_word_t'(flow_table_status);
         `FC_MAC_TCAM_ADDR:      rd_word = bus_word_t'(mac_tcam_addr);
         `FC_MAC_TCAM_DATA:      rd_word = mac_tcam_din[31:0];
         `FC_MAC_TCAM_DATA_MASK: rd_word = {mac_tcam_din_mask[15:0], mac_tcam_din[47:32]};
         `FC_MAC_TCAM_MASK:      rd_word = mac_tcam_din_mask[47:16];
         `FC_IP_TCAM_ADDR:       rd_word = bus_word_t'(ip_tcam_addr);
         `FC_IP_TCAM_DATA:       rd_word = ip_tcam_din;
         `FC_IP_TCAM_MASK:       rd_word = ip_tcam_din_mask;
         // 64-bit timestamps, LSB word first
         `FC_TS_TAP0_LSB:                         rd_word = ts_tap0[31:0];
         `FC_TS_TAP0_LSB + `FC_TS_MSB_STEP:       rd_word = ts_tap0[63:32];
         `FC_TS_TAP1_LSB:                         rd_word = ts_tap1[31:0];
         `FC_TS_TAP1_LSB + `FC_TS_MSB_STEP:       rd_word = ts_tap1[63:32];
         `FC_TS_MAC_FIRST_LSB:                    rd_word = ts_mac_first[31:0];
         `FC_TS_MAC_FIRST_LSB + `FC_TS_MSB_STEP:  rd_word = ts_mac_first[63:32];
         `FC_TS_MAC_LAST_LSB:                     rd_word = ts_mac_last[31:0];
         `FC_TS_MAC_LAST_LSB + `FC_TS_MSB_STEP:   rd_word = ts_mac_last[63:32];
         `FC_TS_IP_FIRST_LSB:                     rd_word = ts_ip_first[31:0];
         `FC_TS_IP_FIRST_LSB + `FC_TS_MSB_STEP:   rd_word = ts_ip_first[63:32];
         `FC_TS_IP_LAST_LSB:                      rd_word = ts_ip_last[31:0];
         `FC_TS_IP_LAST_LSB + `FC_TS_MSB_STEP:    rd_word = ts_ip_last[63:32];
         `FC_TS_TRIG_LSB:                         rd_word = ts_trig[31:0];
         `FC_TS_TRIG_LSB + `FC_TS_MSB_STEP:       rd_word = ts_trig[63:32];
         default:                                 rd_word = '0;
      endcase
   end

   // Last wait cycle, read word is latched here
   assign rd_done = (rd_state == RD_WAIT) && (rd_cnt == CNT_W'(`FC_RD_WAIT));

   always_ff @(posedge Bus2IP_Clk) begin
      if (reset) begin
         rd_state <= RD_IDLE;
         rd_cnt   <= '0;
      end else begin
         case (rd_state)
            RD_IDLE: begin
               if (bus_cs && bus_rnw) begin
                  rd_state <= RD_WAIT;
                  rd_cnt   <= CNT_W'(1);
               end
            end
            RD_WAIT: begin
               if (rd_done) begin
                  rd_state <= RD_ACK;
                  rd_cnt   <= '0;
               end else begin
                  rd_cnt <= rd_cnt + 1'b1;
               end
            end
            // Hold the acknowledge until the host lets go of cs
            RD_ACK: begin
               if (!bus_cs) begin
                  rd_state <= RD_IDLE;
               end
            end
            default: rd_state <= RD_IDLE;
         endcase
      end
   end

   always_ff @(posedge Bus2IP_Clk) begin
      if (rd_done) begin
         bus_rdata <= rd_word;
      end
   end

   assign bus_rd_ack = (rd_state == RD_ACK);

   always_ff @(posedge Bus2IP_Clk) begin
      if (reset) begin
         bus_wr_ack <= 1'b0;
      end else if (bus_wr_ack) begin
         bus_wr_ack <= bus_cs;
      end else if (bus_cs && !bus_rnw) begin
         bus_wr_ack <= 1'b1;
      end
   end

   acks_exclusive: assert property (@(posedge Bus2IP_Clk) disable iff (reset)
      !(bus_rd_ack && bus_wr_ack));

endmodule

`default_nettype wire

// ==== design/event_timestamps.sv ====
`default_nettype none

`include "flow_ctl_consts.svh"

module event_timestamps
   import flow_ctl_pkg::*;
#(
   parameter logic [15:0] BASE_OFFSET = 16'h0000
) (
   input  logic       Bus2IP_Clk,
   input  logic       reset,
   input  logic       bus_cs,
   input  logic       bus_rnw,
   input  bus_addr_t  bus_addr,
   input  bus_word_t  bus_wdata,
   input  timestamp_t ref_counter,
   input  trig_t      flow_table_trig,
   input  logic       mac_tcam_wren,
   input  logic       ip_tcam_wren,
   output timestamp_t ts_tap0,
   output timestamp_t ts_tap1,
   output timestamp_t ts_trig,
   output timestamp_t ts_mac_first,
   output timestamp_t ts_mac_last,
   output timestamp_t ts_ip_first,
   output timestamp_t ts_ip_last
);

   logic [15:0] rel_addr;
   logic        wr_cycle;
   logic        tap0_hit;
   logic        tap1_hit;
   logic        clr_hit;

   // Index 0 is the IP table, index 1 the MAC table, same as the clear bits
   logic [1:0] tbl_wren;
   logic [1:0] tbl_clr;
   logic [1:0] tbl_seen;
   timestamp_t tbl_first [2];
   timestamp_t tbl_last  [2];

   assign rel_addr = bus_addr[15:0] - BASE_OFFSET;
   assign wr_cycle = bus_cs && !bus_rnw;
   assign tap0_hit = wr_cycle && (rel_addr == `FC_TS_TAP0_LSB);
   assign tap1_hit = wr_cycle && (rel_addr == `FC_TS_TAP1_LSB);
   assign clr_hit  = wr_cycle && (rel_addr == `FC_CLR_TS);

   assign tbl_wren = {mac_tcam_wren, ip_tcam_wren};
   assign tbl_clr  = clr_hit ? bus_wdata[1:0] : 2'b00;

   // Taps follow the counter for as long as the write is held
   always_ff @(posedge Bus2IP_Clk) begin
      if (reset) begin
         ts_tap0 <= '0;
         ts_tap1 <= '0;
         ts_trig <= '0;
      end else begin
         if (tap0_hit) begin
            ts_tap0 <= ref_counter;
         end
         if (tap1_hit) begin
            ts_tap1 <= ref_counter;
         end
         if (flow_table_trig != '0) begin
            ts_trig <= ref_counter;
         end
      end
   end

   for (genvar t = 0; t < 2; t++) begin : g_tbl
      // Clear wins over a wren pulse in the same cycle
      always_ff @(posedge Bus2IP_Clk) begin
         if (reset) begin
            tbl_seen[t]  <= 1'b0;
            tbl_first[t] <= '0;
            tbl_last[t]  <= '0;
         end else if (tbl_clr[t]) begin
            tbl_seen[t]  <= 1'b0;
            tbl_first[t] <= '0;
            tbl_last[t]  <= '0;
         end else if (tbl_wren[t]) begin
            tbl_seen[t] <= 1'b1;
            tbl_last[t] <= ref_counter;
            if (!tbl_seen[t]) begin
               tbl_first[t] <= ref_counter;
            end
         end
      end

      first_held: assert property (@(posedge Bus2IP_Clk) disable iff (reset)
         tbl_seen[t] && !tbl_clr[t] |=> $stable(tbl_first[t]));
   end

   assign ts_ip_first  = tbl_first[0];
   assign ts_ip_last   = tbl_last[0];
   assign ts_mac_first = tbl_first[1];
   assign ts_mac_last  = tbl_last[1];

endmodule

`default_nettype wire

// ==== design/flow_ctl_consts.svh ====
`ifndef FLOW_CTL_CONSTS_SVH
`define FLOW_CTL_CONSTS_SVH

// Switch control range, offsets relative to BASE_OFFSET
`define FC_FLOW_TBL_TRIG        16'h1004
`define FC_FLOW_TBL_SEL         16'h100c
// Bit 0 clears IP timestamps, bit 1 clears MAC timestamps
`define FC_CLR_TS               16'h1010
`define FC_FLOW_TBL_CONF        16'h1014
`define FC_FLOW_TBL_STATUS      16'h1018

// MAC TCAM staging
`define FC_MAC_TCAM_ADDR        16'h1100
`define FC_MAC_TCAM_DATA        16'h1104
`define FC_MAC_TCAM_DATA_MASK   16'h1108
`define FC_MAC_TCAM_MASK        16'h110c
`define FC_MAC_TCAM_WREN        16'h1110

// IP TCAM staging
`define FC_IP_TCAM_ADDR         16'h1140
`define FC_IP_TCAM_DATA         16'h1144
`define FC_IP_TCAM_MASK         16'h1148
`define FC_IP_TCAM_WREN         16'h1150

// Timestamp words, each MSB word sits 4 bytes above its LSB word
`define FC_TS_TAP0_LSB          16'h1600
`define FC_TS_TAP1_LSB          16'h1608
`define FC_TS_MAC_FIRST_LSB     16'h1610
`define FC_TS_MAC_LAST_LSB      16'h1618
`define FC_TS_IP_FIRST_LSB      16'h1620
`define FC_TS_IP_LAST_LSB       16'h1628
`define FC_TS_TRIG_LSB          16'h1640
`define FC_TS_MSB_STEP          16'h0004

// Field widths
`define FC_TBL_FIELD_W          6
`define FC_TRIG_W               3

// MAC and port tables start out bypassed
`define FC_CONF_RESET           6'h3c

// Wait cycles before the read acknowledge
`define FC_RD_WAIT              7

`endif

// ==== design/flow_ctl_pkg.sv ====
`default_nettype none

`include "flow_ctl_consts.svh"

package flow_ctl_pkg;

   // Bus side, only address bits 15:0 are decoded
   typedef logic [31:0] bus_addr_t;
   typedef logic [31:0] bus_word_t;

   // TCAM keys and masks
   typedef logic [47:0] mac_addr_t;
   typedef logic [31:0] ip_addr_t;
   typedef logic [3:0]  tbl_index_t;

   // Table selection, configuration and status
   typedef logic [`FC_TBL_FIELD_W-1:0] tbl_field_t;
   typedef logic [`FC_TRIG_W-1:0]      trig_t;

   // Free-running reference counter value
   typedef logic [63:0] timestamp_t;

   // Read wait sequencing
   typedef enum logic [1:0] {
      RD_IDLE,
      RD_WAIT,
      RD_ACK
   } rd_state_e;

endpackage

`default_nettype wire

// ==== design/flow_ctl_top.sv ====
`default_nettype none

module flow_ctl_top
   import flow_ctl_pkg::*;
#(
   parameter logic [15:0] BASE_OFFSET = 16'h0000
) (
   input  logic       Bus2IP_Clk,
   input  logic       reset,
   input  logic       bus_cs,
   input  logic       bus_rnw,
   input  bus_addr_t  bus_addr,
   input  bus_word_t  bus_wdata,
   input  tbl_field_t flow_table_status,
   input  timestamp_t ref_counter,
   output bus_word_t  bus_rdata,
   output logic       bus_rd_ack,
   output logic       bus_wr_ack,
   output tbl_field_t flow_table_sel,
   output tbl_field_t flow_table_config,
   output trig_t      flow_table_trig,
   output tbl_index_t mac_tcam_addr,
   output mac_addr_t  mac_tcam_din,
   output mac_addr_t  mac_tcam_din_mask,
   output logic       mac_tcam_wren,
   output tbl_index_t ip_tcam_addr,
   output ip_addr_t   ip_tcam_din,
   output ip_addr_t   ip_tcam_din_mask,
   output logic       ip_tcam_wren
);

   timestamp_t ts_tap0;
   timestamp_t ts_tap1;
   timestamp_t ts_trig;
   timestamp_t ts_mac_first;
   timestamp_t ts_mac_last;
   timestamp_t ts_ip_first;
   timestamp_t ts_ip_last;

   // Table programming side
   table_program_regs #(
      .BASE_OFFSET (BASE_OFFSET)
   ) u_table_program_regs (
      .Bus2IP_Clk        (Bus2IP_Clk),
      .reset             (reset),
      .bus_cs            (bus_cs),
      .bus_rnw           (bus_rnw),
      .bus_addr          (bus_addr),
      .bus_wdata         (bus_wdata),
      .flow_table_sel    (flow_table_sel),
      .flow_table_config (flow_table_config),
      .flow_table_trig   (flow_table_trig),
      .mac_tcam_addr     (mac_tcam_addr),
      .mac_tcam_din      (mac_tcam_din),
      .mac_tcam_din_mask (mac_tcam_din_mask),
      .mac_tcam_wren     (mac_tcam_wren),
      .ip_tcam_addr      (ip_tcam_addr),
      .ip_tcam_din       (ip_tcam_din),
      .ip_tcam_din_mask  (ip_tcam_din_mask),
      .ip_tcam_wren      (ip_tcam_wren)
   );

   // Event timestamping side
   event_timestamps #(
      .BASE_OFFSET (BASE_OFFSET)
   ) u_event_timestamps (
      .Bus2IP_Clk      (Bus2IP_Clk),
      .reset           (reset),
      .bus_cs          (bus_cs),
      .bus_rnw         (bus_rnw),
      .bus_addr        (bus_addr),
      .bus_wdata       (bus_wdata),
      .ref_counter     (ref_counter),
      .flow_table_trig (flow_table_trig),
      .mac_tcam_wren   (mac_tcam_wren),
      .ip_tcam_wren    (ip_tcam_wren),
      .ts_tap0         (ts_tap0),
      .ts_tap1         (ts_tap1),
      .ts_trig         (ts_trig),
      .ts_mac_first    (ts_mac_first),
      .ts_mac_last     (ts_mac_last),
      .ts_ip_first     (ts_ip_first),
      .ts_ip_last      (ts_ip_last)
   );

   bus_responder #(
      .BASE_OFFSET (BASE_OFFSET)
   ) u_bus_responder (
      .Bus2IP_Clk        (Bus2IP_Clk),
      .reset             (reset),
      .bus_cs            (bus_cs),
      .bus_rnw           (bus_rnw),
      .bus_addr          (bus_addr),
      .flow_table_status (flow_table_status),
      .flow_table_sel    (flow_table_sel),
      .flow_table_config (flow_table_config),
      .mac_tcam_addr     (mac_tcam_addr),
      .mac_tcam_din      (mac_tcam_din),
      .mac_tcam_din_mask (mac_tcam_din_mask),
      .ip_tcam_addr      (ip_tcam_addr),
      .ip_tcam_din       (ip_tcam_din),
      .ip_tcam_din_mask  (ip_tcam_din_mask),
      .ts_tap0           (ts_tap0),
      .ts_tap1           (ts_tap1),
      .ts_trig           (ts_trig),
      .ts_mac_first      (ts_mac_first),
      .ts_mac_last       (ts_mac_last),
      .ts_ip_first       (ts_ip_first),
      .ts_ip_last        (ts_ip_last),
      .bus_rdata         (bus_rdata),
      .bus_rd_ack        (bus_rd_ack),
      .bus_wr_ack        (bus_wr_ack)
   );

endmodule

`default_nettype wire

// ==== design/table_program_regs.sv ====
`default_nettype none

`include "flow_ctl_consts.svh"

module table_program_regs
   import flow_ctl_pkg::*;
#(
   parameter logic [15:0] BASE_OFFSET = 16'h0000
) (
   input  logic       Bus2IP_Clk,
   input  logic       reset,
   input  logic       bus_cs,
   input  logic       bus_rnw,
   input  bus_addr_t  bus_addr,
   input  bus_word_t  bus_wdata,
   output tbl_field_t flow_table_sel,
   output tbl_field_t flow_table_config,
   output trig_t      flow_table_trig,
   output tbl_index_t mac_tcam_addr,
   output mac_addr_t  mac_tcam_din,
   output mac_addr_t  mac_tcam_din_mask,
   output logic       mac_tcam_wren,
   output tbl_index_t ip_tcam_addr,
   output ip_addr_t   ip_tcam_din,
   output ip_addr_t   ip_tcam_din_mask,
   output logic       ip_tcam_wren
);

   logic [15:0] rel_addr;
   logic        wr_cycle;

   logic sel_hit;
   logic conf_hit;
   logic trig_hit;
   logic mac_addr_hit;
   logic mac_data_hit;
   logic mac_data_mask_hit;
   logic mac_mask_hit;
   logic mac_wren_hit;
   logic ip_addr_hit;
   logic ip_data_hit;
   logic ip_mask_hit;
   logic ip_wren_hit;

   // Bit 0 MAC wren, bit 1 IP wren, bit 2 trigger
   logic [2:0] pulse_hit;
   logic [2:0] pulse_hit_d;
   logic [2:0] pulse_rise;

   // Decode relative to the block base
   assign rel_addr = bus_addr[15:0] - BASE_OFFSET;
   assign wr_cycle = bus_cs && !bus_rnw;

   assign sel_hit           = wr_cycle && (rel_addr == `FC_FLOW_TBL_SEL);
   assign conf_hit          = wr_cycle && (rel_addr == `FC_FLOW_TBL_CONF);
   assign trig_hit          = wr_cycle && (rel_addr == `FC_FLOW_TBL_TRIG);
   assign mac_addr_hit      = wr_cycle && (rel_addr == `FC_MAC_TCAM_ADDR);
   assign mac_data_hit      = wr_cycle && (rel_addr == `FC_MAC_TCAM_DATA);
   assign mac_data_mask_hit = wr_cycle && (rel_addr == `FC_MAC_TCAM_DATA_MASK);
   assign mac_mask_hit      = wr_cycle && (rel_addr == `FC_MAC_TCAM_MASK);
   assign mac_wren_hit      = wr_cycle && (rel_addr == `FC_MAC_TCAM_WREN);
   assign ip_addr_hit       = wr_cycle && (rel_addr == `FC_IP_TCAM_ADDR);
   assign ip_data_hit       = wr_cycle && (rel_addr == `FC_IP_TCAM_DATA);
   assign ip_mask_hit       = wr_cycle && (rel_addr == `FC_IP_TCAM_MASK);
   assign ip_wren_hit       = wr_cycle && (rel_addr == `FC_IP_TCAM_WREN);

   always_ff @(posedge Bus2IP_Clk) begin
      if (reset) begin
         flow_table_sel    <= '0;
         flow_table_config <= `FC_CONF_RESET;
      end else begin
         if (sel_hit) begin
            flow_table_sel <= bus_wdata[`FC_TBL_FIELD_W-1:0];
         end
         if (conf_hit) begin
            flow_table_config <= bus_wdata[`FC_TBL_FIELD_W-1:0];
         end
      end
   end

   // MAC key and mask are built from three staggered words
   always_ff @(posedge Bus2IP_Clk) begin
      if (mac_addr_hit) begin
         mac_tcam_addr <= bus_wdata[$bits(tbl_index_t)-1:0];
      end
      if (mac_data_hit) begin
         mac_tcam_din[31:0] <= bus_wdata;
      end
      if (mac_data_mask_hit) begin
         mac_tcam_din[47:32]     <= bus_wdata[15:0];
         mac_tcam_din_mask[15:0] <= bus_wdata[31:16];
      end
      if (mac_mask_hit) begin
         mac_tcam_din_mask[47:16] <= bus_wdata;
      end
   end

   always_ff @(posedge Bus2IP_Clk) begin
      if (ip_addr_hit) begin
         ip_tcam_addr <= bus_wdata[$bits(tbl_index_t)-1:0];
      end
      if (ip_data_hit) begin
         ip_tcam_din <= bus_wdata;
      end
      if (ip_mask_hit) begin
         ip_tcam_din_mask <= bus_wdata;
      end
   end

   // One pulse per transaction however long the host holds cs
   assign pulse_hit  = {trig_hit, ip_wren_hit, mac_wren_hit};
   assign pulse_rise = pulse_hit & ~pulse_hit_d;

   always_ff @(posedge Bus2IP_Clk) begin
      if (reset) begin
         pulse_hit_d     <= '0;
         mac_tcam_wren   <= 1'b0;
         ip_tcam_wren    <= 1'b0;
         flow_table_trig <= '0;
      end else begin
         pulse_hit_d     <= pulse_hit;
         mac_tcam_wren   <= pulse_rise[0];
         ip_tcam_wren    <= pulse_rise[1];
         flow_table_trig <= pulse_rise[2] ? bus_wdata[`FC_TRIG_W-1:0] : '0;
      end
   end

   mac_wren_single: assert property (@(posedge Bus2IP_Clk) disable iff (reset)
      mac_tcam_wren |=> !mac_tcam_wren);

   ip_wren_single: assert property (@(posedge Bus2IP_Clk) disable iff (reset)
      ip_tcam_wren |=> !ip_tcam_wren);

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/flow_ctl_pkg.sv
design/table_program_regs.sv
design/event_timestamps.sv
design/bus_responder.sv
design/flow_ctl_top.sv
tb/tb_clock_gen.sv
tb/flow_ctl_tb.sv

// ==== tb/flow_ctl_tb.sv ====
`default_nettype none

`include "flow_ctl_consts.svh"

module flow_ctl_tb
   import flow_ctl_pkg::*;
();

   timeunit 1ns;
   timeprecision 100ps;

   localparam logic [15:0] BASE = 16'h2000;
   localparam int ACK_TIMEOUT = 40;
   localparam logic [15:0] TS_OFFS [7] = '{`FC_TS_TAP0_LSB, `FC_TS_TAP1_LSB,
      `FC_TS_MAC_FIRST_LSB, `FC_TS_MAC_LAST_LSB, `FC_TS_IP_FIRST_LSB,
      `FC_TS_IP_LAST_LSB, `FC_TS_TRIG_LSB};

   logic       Bus2IP_Clk;
   logic       reset;
   logic       bus_cs;
   logic       bus_rnw;
   bus_addr_t  bus_addr;
   bus_word_t  bus_wdata;
   tbl_field_t flow_table_status;
   timestamp_t ref_counter;
   bus_word_t  bus_rdata;
   logic       bus_rd_ack;
   logic       bus_wr_ack;
   tbl_field_t flow_table_sel;
   tbl_field_t flow_table_config;
   trig_t      flow_table_trig;
   tbl_index_t mac_tcam_addr;
   mac_addr_t  mac_tcam_din;
   mac_addr_t  mac_tcam_din_mask;
   logic       mac_tcam_wren;
   tbl_index_t ip_tcam_addr;
   ip_addr_t   ip_tcam_din;
   ip_addr_t   ip_tcam_din_mask;
   logic       ip_tcam_wren;

   // Reference model of the timestamps and pulse counters
   timestamp_t  exp_tap0;
   timestamp_t  exp_tap1;
   timestamp_t  exp_trig;
   timestamp_t  exp_mac_first;
   timestamp_t  exp_mac_last;
   timestamp_t  exp_ip_first;
   timestamp_t  exp_ip_last;
   logic        mac_seen;
   logic        ip_seen;
   int          mac_pulses;
   int          ip_pulses;
   int          trig_pulses;
   trig_t       last_trig;
   logic [31:0] rand_state = 32'd17;

   tb_clock_gen u_clock_gen (
      .Bus2IP_Clk (Bus2IP_Clk),
      .reset      (reset)
   );

   flow_ctl_top #(
      .BASE_OFFSET (BASE)
   ) uut (
      .Bus2IP_Clk        (Bus2IP_Clk),
      .reset             (reset),
      .bus_cs            (bus_cs),
      .bus_rnw           (bus_rnw),
      .bus_addr          (bus_addr),
      .bus_wdata         (bus_wdata),
      .flow_table_status (flow_table_status),
      .ref_counter       (ref_counter),
      .bus_rdata         (bus_rdata),
      .bus_rd_ack        (bus_rd_ack),
      .bus_wr_ack        (bus_wr_ack),
      .flow_table_sel    (flow_table_sel),
      .flow_table_config (flow_table_config),
      .flow_table_trig   (flow_table_trig),
      .mac_tcam_addr     (mac_tcam_addr),
      .mac_tcam_din      (mac_tcam_din),
      .mac_tcam_din_mask (mac_tcam_din_mask),
      .mac_tcam_wren     (mac_tcam_wren),
      .ip_tcam_addr      (ip_tcam_addr),
      .ip_tcam_din       (ip_tcam_din),
      .ip_tcam_din_mask  (ip_tcam_din_mask),
      .ip_tcam_wren      (ip_tcam_wren)
   );

   task automatic abort_run(input string why);
      $display("%s", why);
      $display("Something failed");
      $fatal(1, "Run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] got,
                              input logic [63:0] exp);
      assert (got === exp) else begin
         abort_run($sformatf("Mismatch at %0t ns: %s is %h, expected %h",
                             $time, name, got, exp));
      end
   endtask

   function automatic bus_word_t next_random();
      rand_state = rand_state * 32'd1664525 + 32'd1013904223;
      return rand_state;
   endfunction

   // Upper address bits are ignored by the decoder
   function automatic bus_addr_t reg_addr(input logic [15:0] off);
      return {16'h5a00, BASE + off};
   endfunction

   function automatic logic is_write_to(input logic [15:0] off);
      return bus_cs && !bus_rnw && (bus_addr[15:0] == BASE + off);
   endfunction

   // Host write, held for extra cycles after the acknowledge
   task automatic bus_write(input logic [15:0] off, input bus_word_t data, input int hold);
      int cycles;
      bus_cs    = 1'b1;
      bus_rnw   = 1'b0;
      bus_addr  = reg_addr(off);
      bus_wdata = data;
      cycles    = 0;
      while (!bus_wr_ack) begin
         @(negedge Bus2IP_Clk);
         cycles++;
         if (cycles > ACK_TIMEOUT) abort_run("Timed out waiting for bus_wr_ack");
      end
      check_value("bus_wr_ack latency", cycles, 1);
      repeat (hold) @(negedge Bus2IP_Clk);
      bus_cs  = 1'b0;
      bus_rnw = 1'b1;
      @(negedge Bus2IP_Clk);
   endtask

   task automatic bus_read(input logic [15:0] off, output bus_word_t data);
      int cycles;
      bus_cs   = 1'b1;
      bus_rnw  = 1'b1;
      bus_addr = reg_addr(off);
      cycles   = 0;
      while (!bus_rd_ack) begin
         @(negedge Bus2IP_Clk);
         cycles++;
         if (cycles > ACK_TIMEOUT) abort_run("Timed out waiting for bus_rd_ack");
      end
      check_value("bus_rd_ack latency", cycles, `FC_RD_WAIT + 1);
      data   = bus_rdata;
      bus_cs = 1'b0;
      @(negedge Bus2IP_Clk);
   endtask

   task automatic read_check(input logic [15:0] off, input string name,
                             input logic [63:0] exp);
      bus_word_t data;
      bus_read(off, data);
      check_value(name, data, exp);
   endtask

   task automatic read_timestamp(input logic [15:0] lsb_off, input string name,
                                 input timestamp_t exp);
      bus_word_t lo;
      bus_word_t hi;
      bus_read(lsb_off, lo);
      bus_read(lsb_off + `FC_TS_MSB_STEP, hi);
      check_value(name, {hi, lo}, exp);
   endtask

   task automatic check_timestamps();
      read_timestamp(`FC_TS_TAP0_LSB, "ts_tap0", exp_tap0);
      read_timestamp(`FC_TS_TAP1_LSB, "ts_tap1", exp_tap1);
      read_timestamp(`FC_TS_TRIG_LSB, "ts_trig", exp_trig);
      read_timestamp(`FC_TS_MAC_FIRST_LSB, "ts_mac_first", exp_mac_first);
      read_timestamp(`FC_TS_MAC_LAST_LSB, "ts_mac_last", exp_mac_last);
      read_timestamp(`FC_TS_IP_FIRST_LSB, "ts_ip_first", exp_ip_first);
      read_timestamp(`FC_TS_IP_LAST_LSB, "ts_ip_last", exp_ip_last);
   endtask

   initial ref_counter = 64'h0000_0002_ffff_ff00;

   always @(negedge Bus2IP_Clk) begin
      ref_counter <= ref_counter + 1'b1;
   end

   // Events as the flops see them at this edge
   always @(posedge Bus2IP_Clk) begin
      if (reset) begin
         {exp_tap0, exp_tap1, exp_trig} = '0;
         {exp_mac_first, exp_mac_last, exp_ip_first, exp_ip_last} = '0;
         mac_seen    = 1'b0;
         ip_seen     = 1'b0;
         mac_pulses  = 0;
         ip_pulses   = 0;
         trig_pulses = 0;
         last_trig   = '0;
      end else begin
         if (is_write_to(`FC_TS_TAP0_LSB)) exp_tap0 = ref_counter;
         if (is_write_to(`FC_TS_TAP1_LSB)) exp_tap1 = ref_counter;
         if (flow_table_trig != '0) begin
            exp_trig = ref_counter;
            last_trig = flow_table_trig;
            trig_pulses++;
         end
         if (mac_tcam_wren) begin
            mac_pulses++;
            if (!mac_seen) exp_mac_first = ref_counter;
            mac_seen = 1'b1;
            exp_mac_last = ref_counter;
         end
         if (ip_tcam_wren) begin
            ip_pulses++;
            if (!ip_seen) exp_ip_first = ref_counter;
            ip_seen = 1'b1;
            exp_ip_last = ref_counter;
         end
         if (is_write_to(`FC_CLR_TS) && bus_wdata[0]) begin
            ip_seen = 1'b0;
            exp_ip_first = '0;
            exp_ip_last = '0;
         end
         if (is_write_to(`FC_CLR_TS) && bus_wdata[1]) begin
            mac_seen = 1'b0;
            exp_mac_first = '0;
            exp_mac_last = '0;
         end
      end
   end

   outputs_idle_after_reset: assert property (@(posedge Bus2IP_Clk) $fell(reset) |->
      !bus_rd_ack && !bus_wr_ack && !mac_tcam_wren && !ip_tcam_wren && flow_table_trig == '0)
      else abort_run("Outputs were not inactive when reset was released");

   wr_ack_after_write: assert property (@(posedge Bus2IP_Clk) disable iff (reset)
      $rose(bus_wr_ack) |-> $past(bus_cs && !bus_rnw))
      else abort_run("bus_wr_ack rose without a sampled write");

   rd_ack_after_wait: assert property (@(posedge Bus2IP_Clk) disable iff (reset)
      $rose(bus_rd_ack) |-> $past(bus_cs && bus_rnw, `FC_RD_WAIT + 1))
      else abort_run("bus_rd_ack rose without a read sampled 8 cycles before");

   trig_single_cycle: assert property (@(posedge Bus2IP_Clk) disable iff (reset)
      flow_table_trig != '0 |=> flow_table_trig == '0)
      else abort_run("flow_table_trig was high for more than one cycle");

   initial begin
      bus_word_t w;
      bus_word_t d;
      bus_word_t dm;
      bus_word_t m;
      int        n;
      int        cycles;

      bus_cs            = 1'b0;
      bus_rnw           = 1'b1;
      bus_addr          = '0;
      bus_wdata         = '0;
      flow_table_status = '0;

      // Reset changes on a falling edge, so it is sampled on the rising one
      cycles = 0;
      @(posedge Bus2IP_Clk);
      while (reset) begin
         @(posedge Bus2IP_Clk);
         cycles++;
         if (cycles > 20) abort_run("Reset was never released");
      end
      @(negedge Bus2IP_Clk);

      // Reset values
      check_value("bus_rd_ack", bus_rd_ack, 0);
      check_value("bus_wr_ack", bus_wr_ack, 0);
      check_value("mac_tcam_wren", mac_tcam_wren, 0);
      check_value("ip_tcam_wren", ip_tcam_wren, 0);
      check_value("flow_table_trig", flow_table_trig, 0);
      read_check(`FC_FLOW_TBL_CONF, "flow table config word", 8'h3c);
      read_check(`FC_FLOW_TBL_SEL, "flow table sel word", 0);
      foreach (TS_OFFS[i]) begin
         read_timestamp(TS_OFFS[i], $sformatf("timestamp at %h", TS_OFFS[i]), '0);
      end

      // Register readback and TCAM staging
      repeat (4) begin
         w = next_random();
         bus_write(`FC_FLOW_TBL_SEL, w, 0);
         read_check(`FC_FLOW_TBL_SEL, "flow table sel word", w[5:0]);
         check_value("flow_table_sel", flow_table_sel, w[5:0]);
         w = next_random();
         bus_write(`FC_FLOW_TBL_CONF, w, 1);
         read_check(`FC_FLOW_TBL_CONF, "flow table config word", w[5:0]);
         check_value("flow_table_config", flow_table_config, w[5:0]);

         w = next_random();
         d = next_random();
         dm = next_random();
         m = next_random();
         bus_write(`FC_MAC_TCAM_ADDR, w, 0);
         bus_write(`FC_MAC_TCAM_DATA, d, 0);
         bus_write(`FC_MAC_TCAM_DATA_MASK, dm, 2);
         bus_write(`FC_MAC_TCAM_MASK, m, 0);
         read_check(`FC_MAC_TCAM_ADDR, "mac tcam addr word", w[3:0]);
         read_check(`FC_MAC_TCAM_DATA, "mac tcam data word", d);
         read_check(`FC_MAC_TCAM_DATA_MASK, "mac tcam data mask word", dm);
         read_check(`FC_MAC_TCAM_MASK, "mac tcam mask word", m);
         check_value("mac_tcam_addr", mac_tcam_addr, w[3:0]);
         check_value("mac_tcam_din", mac_tcam_din, {dm[15:0], d});
         check_value("mac_tcam_din_mask", mac_tcam_din_mask, {m, dm[31:16]});

         w = next_random();
         d = next_random();
         m = next_random();
         bus_write(`FC_IP_TCAM_ADDR, w, 0);
         bus_write(`FC_IP_TCAM_DATA, d, 1);
         bus_write(`FC_IP_TCAM_MASK, m, 0);
         read_check(`FC_IP_TCAM_ADDR, "ip tcam addr word", w[3:0]);
         read_check(`FC_IP_TCAM_DATA, "ip tcam data word", d);
         read_check(`FC_IP_TCAM_MASK, "ip tcam mask word", m);
         check_value("ip_tcam_addr", ip_tcam_addr, w[3:0]);
         check_value("ip_tcam_din", ip_tcam_din, d);
         check_value("ip_tcam_din_mask", ip_tcam_din_mask, m);

         w = next_random();
         flow_table_status = w[5:0];
         read_check(`FC_FLOW_TBL_STATUS, "flow table status word", w[5:0]);
         read_check(16'h1200, "unmapped word", 0);
      end

      // One pulse per held transaction
      n = mac_pulses;
      bus_write(`FC_MAC_TCAM_WREN, next_random(), 5);
      check_value("mac_tcam_wren pulse count", mac_pulses, n + 1);
      n = ip_pulses;
      bus_write(`FC_IP_TCAM_WREN, next_random(), 3);
      check_value("ip_tcam_wren pulse count", ip_pulses, n + 1);
      w = next_random();
      if (w[2:0] == 3'b000) w[0] = 1'b1;
      n = trig_pulses;
      bus_write(`FC_FLOW_TBL_TRIG, w, 4);
      check_value("flow_table_trig pulse count", trig_pulses, n + 1);
      check_value("flow_table_trig", last_trig, w[2:0]);

      // Timestamp capture
      bus_write(`FC_TS_TAP0_LSB, next_random(), 3);
      bus_write(`FC_TS_TAP1_LSB, next_random(), 0);
      repeat (2) begin
         bus_write(`FC_MAC_TCAM_WREN, next_random(), 1);
         bus_write(`FC_IP_TCAM_WREN, next_random(), 0);
      end
      bus_write(`FC_FLOW_TBL_TRIG, 32'h6, 2);
      check_timestamps();

      // Clear IP only, then MAC only
      bus_write(`FC_CLR_TS, 32'h1, 0);
      check_timestamps();
      bus_write(`FC_IP_TCAM_WREN, next_random(), 2);
      check_timestamps();
      bus_write(`FC_CLR_TS, 32'h2, 1);
      check_timestamps();
      bus_write(`FC_MAC_TCAM_WREN, next_random(), 0);
      bus_write(`FC_MAC_TCAM_WREN, next_random(), 0);
      check_timestamps();

      $display("Everything OK");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/tb_clock_gen.sv ====
`default_nettype none

module tb_clock_gen (
   output logic Bus2IP_Clk,
   output logic reset
);

   timeunit 1ns;
   timeprecision 100ps;

   localparam int RESET_CYCLES = 3;

   // 8 ns period
   initial begin
      Bus2IP_Clk = 1'b0;
      forever #4 Bus2IP_Clk = ~Bus2IP_Clk;
   end

   // Reset is released on a falling edge, like the rest of the stimulus
   initial begin
      reset = 1'b1;
      repeat (RESET_CYCLES) @(posedge Bus2IP_Clk);
      @(negedge Bus2IP_Clk);
      reset = 1'b0;
   end

endmodule

`default_nettype wire
